// ==== logic/dmr_reg_pkg.sv ====
// Register map of the DMR control block: addresses, data width and the configuration word
package dmr_reg_pkg;

  // Width of the register data port
  localparam int unsigned RegWidth = 32;

  // Word addresses on the register port
  typedef enum logic [1:0] {
    DMR_ENABLE_ADDR   = 2'd0,
    DMR_CONFIG_ADDR   = 2'd1,
    DMR_MISMATCH_ADDR = 2'd2,
    DMR_STATUS_ADDR   = 2'd3
  } reg_addr_e;

  // Field view of the configuration word, LSB last
  typedef struct packed {
    logic [RegWidth-3:0] reserved;
    // Self-clearing, a write of 1 starts one restore
    logic                force_recovery;
    // Selects hardware restore over software resynch
    logic                rapid_recovery;
  } dmr_config_fields_t;

  // Configuration word
  // The register port moves it as a raw word, the hardware reads the fields
  typedef union packed {
    logic [RegWidth-1:0] raw;
    dmr_config_fields_t  fields;
  } dmr_config_t;

endpackage

// ==== logic/dmr_mode_pkg.sv ====
// Redundancy mode and setback encodings shared by the DMR FSM, registers and testbench
package dmr_mode_pkg;

  // Mode of the core pair, encoding 3 is unused
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Setback codes driven to the cores on a mode transition
  localparam logic [1:0] SetbackNone  = 2'b00;
  // Leaving lockstep, cores continue independently
  localparam logic [1:0] SetbackSplit = 2'b10;
  // Entering lockstep after synchronisation
  localparam logic [1:0] SetbackJoin  = 2'b11;

endpackage

// ==== logic/dmr_ctrl_regs.sv ====
// Software registers of the DMR subsystem: enable, configuration, mismatch count and status
`timescale 1ns/10ps

module dmr_ctrl_regs #(
  parameter bit RapidRecovery = 1'b0,
  parameter bit DmrFixed      = 1'b0
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              reg_valid_i,
  input  logic                              reg_write_i,
  input  dmr_reg_pkg::reg_addr_e            reg_addr_i,
  input  logic [dmr_reg_pkg::RegWidth-1:0]  reg_wdata_i,
  output logic [dmr_reg_pkg::RegWidth-1:0]  reg_rdata_o,
  input  logic                              dmr_error_i,
  input  dmr_mode_pkg::dmr_mode_e           mode_i,
  output logic                              dmr_enable_o,
  output logic                              rapid_recovery_o,
  output logic                              force_recovery_o
);
  import dmr_reg_pkg::*;

  logic                reg_wr, reg_rd;
  logic                mismatch_clr;
  logic                enable_q;
  logic                force_q;
  dmr_config_t         wdata_cfg, cfg_d, cfg_q;
  logic [RegWidth-1:0] mismatch_q;
  logic [RegWidth-1:0] rdata_d, rdata_q;

  assign reg_wr       = reg_valid_i & reg_write_i;
  assign reg_rd       = reg_valid_i & ~reg_write_i;
  assign mismatch_clr = reg_wr && (reg_addr_i == DMR_MISMATCH_ADDR);

  // Write data taken raw, stored with force cleared and rapid masked by the build option
  always_comb begin
    wdata_cfg.raw = reg_wdata_i;
    cfg_d = wdata_cfg;
    cfg_d.fields.force_recovery = 1'b0;
    cfg_d.fields.rapid_recovery = wdata_cfg.fields.rapid_recovery & RapidRecovery;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q   <= 1'b0;
      cfg_q      <= '0;
      force_q    <= 1'b0;
      mismatch_q <= '0;
    end else begin
      if (reg_wr && reg_addr_i == DMR_ENABLE_ADDR) begin
        enable_q <= reg_wdata_i[0];
      end
      if (reg_wr && reg_addr_i == DMR_CONFIG_ADDR) begin
        cfg_q <= cfg_d;
      end
      // One-cycle pulse towards the FSM
      force_q <= reg_wr && (reg_addr_i == DMR_CONFIG_ADDR) && wdata_cfg.fields.force_recovery;
      if (mismatch_clr) begin
        mismatch_q <= '0;
      end else if (dmr_error_i && mismatch_q != {RegWidth{1'b1}}) begin
        mismatch_q <= mismatch_q + 1'b1;
      end
    end
  end

  assign dmr_enable_o     = enable_q | DmrFixed;
  assign rapid_recovery_o = cfg_q.fields.rapid_recovery;
  assign force_recovery_o = force_q;

  // Read mux
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      DMR_ENABLE_ADDR:   rdata_d = {{(RegWidth-1){1'b0}}, dmr_enable_o};
      DMR_CONFIG_ADDR:   rdata_d = cfg_q.raw;
      DMR_MISMATCH_ADDR: rdata_d = mismatch_q;
      DMR_STATUS_ADDR:   rdata_d = RegWidth'(mode_i);
    endcase
  end

  // Read data holds between read strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (reg_rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o = rdata_q;

  a_mismatch_monotonic: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !mismatch_clr |=> mismatch_q >= $past(mismatch_q));

endmodule

// ==== logic/dmr_lockstep_cmp.sv ====
// Lockstep comparator, flags a mismatch of the two cores' output words one cycle after the sample
`timescale 1ns/10ps

module dmr_lockstep_cmp #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 core_valid_i,
  input  logic [DataWidth-1:0] core_a_data_i,
  input  logic [DataWidth-1:0] core_b_data_i,
  output logic                 dmr_error_o
);

  logic [DataWidth-1:0] diff;
  logic                 mismatch;
  logic                 error_q;

  // Any differing bit counts, the failing core cannot be told apart
  assign diff     = core_a_data_i ^ core_b_data_i;
  assign mismatch = |diff;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q <= 1'b0;
    end else begin
      error_q <= core_valid_i & mismatch;
    end
  end

  assign dmr_error_o = error_q;

  a_error_after_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmr_error_o |-> $past(core_valid_i));

endmodule

// ==== logic/dmr_recovery_seq.sv ====
// Restore sequencer standing in for the state-restore engine, times one restore of fixed length
`timescale 1ns/10ps

module dmr_recovery_seq #(
  parameter int unsigned RestoreCycles = 8
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic recovery_request_i,
  output logic recovery_finished_o
);

  localparam int unsigned CntWidth = $clog2(RestoreCycles + 1);

  logic [CntWidth-1:0] cnt_q;
  logic                active_q;
  logic                done_q;

  // Terminal count reached
  assign recovery_finished_o = active_q && (cnt_q == CntWidth'(RestoreCycles));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (recovery_finished_o) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b1;
    end else if (active_q) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (recovery_request_i && !done_q) begin
      // Arm on the first edge that sees the request
      cnt_q    <= CntWidth'(1);
      active_q <= 1'b1;
    end else if (!recovery_request_i) begin
      done_q <= 1'b0;
    end
  end

  a_finished_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_finished_o |-> recovery_request_i);

endmodule

// ==== logic/dmr_ctrl.sv ====
// Redundancy mode FSM of the core pair, issues synch requests, setbacks and restore requests
`timescale 1ns/10ps

module dmr_ctrl #(
  parameter bit DmrFixed      = 1'b0,
  parameter bit DefaultInDmr  = DmrFixed,
  parameter bit RapidRecovery = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_en_i,
  input  logic                    cores_synch_i,
  input  logic                    dmr_enable_i,
  input  logic                    rapid_recovery_i,
  input  logic                    force_recovery_i,
  input  logic                    dmr_error_i,
  input  logic                    recovery_finished_i,
  output dmr_mode_pkg::dmr_mode_e mode_o,
  output logic [1:0]              setback_o,
  output logic                    sw_synch_req_o,
  output logic                    sw_resynch_req_o,
  output logic                    grp_in_independent_o,
  output logic                    rapid_recovery_en_o,
  output logic                    recovery_request_o
);
  import dmr_mode_pkg::*;

  localparam dmr_mode_e DefaultMode = (DmrFixed || DefaultInDmr) ? DMR_RUN : NON_DMR;

  dmr_mode_e mode_d, mode_q;
  logic      rapid_en;
  logic      synch_req, synch_req_q;
  logic      resynch_req, resynch_req_q;
  logic      cores_synch_q;

  assign rapid_en             = rapid_recovery_i & RapidRecovery;
  assign rapid_recovery_en_o  = rapid_en;
  assign grp_in_independent_o = (mode_q == NON_DMR);
  assign recovery_request_o   = (mode_q == DMR_RESTORE);
  assign mode_o               = mode_q;

  // Requests pulse on their rising edge only
  assign sw_synch_req_o   = synch_req & ~synch_req_q;
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;

  always_comb begin
    mode_d      = mode_q;
    setback_o   = SetbackNone;
    synch_req   = 1'b0;
    resynch_req = 1'b0;

    case (mode_q)
      DMR_RUN: begin
        if ((dmr_error_i || force_recovery_i) && rapid_en) begin
          mode_d = DMR_RESTORE;
        end
        if (dmr_error_i && !rapid_en) begin
          resynch_req = 1'b1;
        end
      end
      DMR_RESTORE: begin
        if (recovery_finished_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: ;
    endcase

    if (!DmrFixed) begin
      // Join once software reports both cores synchronised
      if (mode_q == NON_DMR && dmr_enable_i) begin
        synch_req = 1'b1;
        if (cores_synch_q) begin
          if (rapid_en) begin
            mode_d = DMR_RESTORE;
          end else begin
            mode_d    = DMR_RUN;
            setback_o = SetbackJoin;
          end
        end
      end
      // Before the cores fetch, the mode simply follows the enable
      if (!fetch_en_i) begin
        if (!dmr_enable_i) begin
          mode_d = NON_DMR;
        end else begin
          synch_req = 1'b0;
          mode_d    = DMR_RUN;
        end
      end
      // Split back to independent mode at any time from lockstep run
      if (mode_q == DMR_RUN && !dmr_enable_i) begin
        mode_d    = NON_DMR;
        setback_o = SetbackSplit;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= DefaultMode;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
      cores_synch_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
      cores_synch_q <= cores_synch_i;
    end
  end

  a_mode_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode_q inside {NON_DMR, DMR_RUN, DMR_RESTORE});

endmodule

// ==== logic/dmr_subsys_top.sv ====
// Top of the DMR control subsystem, ties registers, comparator, mode FSM and restore sequencer
`timescale 1ns/10ps

module dmr_subsys_top #(
  parameter bit          DmrFixed      = 1'b0,
  parameter bit          DefaultInDmr  = DmrFixed,
  parameter bit          RapidRecovery = 1'b0,
  parameter int unsigned DataWidth     = 32,
  parameter int unsigned RestoreCycles = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             reg_valid_i,
  input  logic                             reg_write_i,
  input  dmr_reg_pkg::reg_addr_e           reg_addr_i,
  input  logic [dmr_reg_pkg::RegWidth-1:0] reg_wdata_i,
  output logic [dmr_reg_pkg::RegWidth-1:0] reg_rdata_o,
  input  logic                             fetch_en_i,
  input  logic                             cores_synch_i,
  input  logic                             core_valid_i,
  input  logic [DataWidth-1:0]             core_a_data_i,
  input  logic [DataWidth-1:0]             core_b_data_i,
  output logic [1:0]                       setback_o,
  output logic                             sw_synch_req_o,
  output logic                             sw_resynch_req_o,
  output logic                             grp_in_independent_o,
  output logic                             rapid_recovery_en_o,
  output logic                             recovery_busy_o
);
  import dmr_mode_pkg::*;

  logic      dmr_enable;
  logic      rapid_recovery;
  logic      force_recovery;
  logic      dmr_error;
  logic      recovery_finished;
  dmr_mode_e mode;

  dmr_ctrl_regs #(
    .RapidRecovery(RapidRecovery),
    .DmrFixed     (DmrFixed)
  ) i_dmr_ctrl_regs (
    .clk_i,
    .rst_ni,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .dmr_error_i     (dmr_error),
    .mode_i          (mode),
    .dmr_enable_o    (dmr_enable),
    .rapid_recovery_o(rapid_recovery),
    .force_recovery_o(force_recovery)
  );

  dmr_lockstep_cmp #(
    .DataWidth(DataWidth)
  ) i_dmr_lockstep_cmp (
    .clk_i,
    .rst_ni,
    .core_valid_i,
    .core_a_data_i,
    .core_b_data_i,
    .dmr_error_o(dmr_error)
  );

  dmr_ctrl #(
    .DmrFixed     (DmrFixed),
    .DefaultInDmr (DefaultInDmr),
    .RapidRecovery(RapidRecovery)
  ) i_dmr_ctrl (
    .clk_i,
    .rst_ni,
    .fetch_en_i,
    .cores_synch_i,
    .dmr_enable_i       (dmr_enable),
    .rapid_recovery_i   (rapid_recovery),
    .force_recovery_i   (force_recovery),
    .dmr_error_i        (dmr_error),
    .recovery_finished_i(recovery_finished),
    .mode_o             (mode),
    .setback_o,
    .sw_synch_req_o,
    .sw_resynch_req_o,
    .grp_in_independent_o,
    .rapid_recovery_en_o,
    // Restore request doubles as the busy flag
    .recovery_request_o (recovery_busy_o)
  );

  dmr_recovery_seq #(
    .RestoreCycles(RestoreCycles)
  ) i_dmr_recovery_seq (
    .clk_i,
    .rst_ni,
    .recovery_request_i (recovery_busy_o),
    .recovery_finished_o(recovery_finished)
  );

endmodule

// ==== tb/tb_dmr_subsys.sv ====
// Table-driven testbench of the DMR control subsystem, built and run with verilog.f as top
`timescale 1ns/10ps

module tb_dmr_subsys;
  import dmr_reg_pkg::*;
  import dmr_mode_pkg::*;

  localparam int unsigned DataWidth     = 32;
  localparam int unsigned RestoreCycles = 8;
  localparam int          NumSteps      = 15;
  localparam int          ResetCycles   = 16;

  // One table row, stimulus first, then what is expected over its wait window
  typedef struct packed {
    logic                fetch_en;
    logic                synch;
    logic                rd;
    logic                wr;
    reg_addr_e           addr;
    logic [RegWidth-1:0] wdata;
    logic                cmp;
    logic                differ;
    int                  wait_cyc;
    int                  exp_synch;
    int                  exp_resynch;
    logic [1:0]          exp_setback;
    int                  exp_busy;
    logic                exp_indep;
    logic                exp_rapid;
    logic [RegWidth-1:0] exp_rdata;
  } step_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 reg_valid_i;
  logic                 reg_write_i;
  reg_addr_e            reg_addr_i;
  logic [RegWidth-1:0]  reg_wdata_i;
  logic [RegWidth-1:0]  reg_rdata_o;
  logic                 fetch_en_i;
  logic                 cores_synch_i;
  logic                 core_valid_i;
  logic [DataWidth-1:0] core_a_data_i;
  logic [DataWidth-1:0] core_b_data_i;
  logic [1:0]           setback_o;
  logic                 sw_synch_req_o;
  logic                 sw_resynch_req_o;
  logic                 grp_in_independent_o;
  logic                 rapid_recovery_en_o;
  logic                 recovery_busy_o;

  step_t      steps [NumSteps];
  string      names [NumSteps];
  integer     seed         = 32'h88d1_add9;
  int         errors       = 0;
  int         failed_steps = 0;
  int         cycles       = 0;
  int         cycle_limit  = 100000;
  int         synch_cnt;
  int         resynch_cnt;
  int         busy_cnt;
  logic [1:0] setback_seen;

  dmr_subsys_top #(
    .RapidRecovery(1'b1),
    .DataWidth    (DataWidth),
    .RestoreCycles(RestoreCycles)
  ) i_dmr_subsys_top (
    .clk_i,
    .rst_ni,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .fetch_en_i,
    .cores_synch_i,
    .core_valid_i,
    .core_a_data_i,
    .core_b_data_i,
    .setback_o,
    .sw_synch_req_o,
    .sw_resynch_req_o,
    .grp_in_independent_o,
    .rapid_recovery_en_o,
    .recovery_busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [RegWidth-1:0] got,
                            input logic [RegWidth-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mode(input string name, input dmr_mode_e got, input dmr_mode_e exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is mode %0d, expected mode %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_setback(input string name, input logic [1:0] got,
                               input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // Tally pulses, busy cycles and the last setback seen in this cycle
  task automatic sample_outputs();
    if (sw_synch_req_o) synch_cnt++;
    if (sw_resynch_req_o) resynch_cnt++;
    if (recovery_busy_o) busy_cnt++;
    if (setback_o != SetbackNone) setback_seen = setback_o;
  endtask

  task automatic drive_step(input step_t s);
    logic [DataWidth-1:0] word;
    logic [DataWidth-1:0] flip;
    word = $random(seed);
    flip = $random(seed);
    fetch_en_i    = s.fetch_en;
    cores_synch_i = s.synch;
    reg_valid_i   = s.rd | s.wr;
    reg_write_i   = s.wr;
    reg_addr_i    = s.addr;
    reg_wdata_i   = s.wdata;
    core_valid_i  = s.cmp;
    core_a_data_i = word;
    // At least bit 0 differs on a mismatch step
    core_b_data_i = s.differ ? (word ^ (flip | 32'h1)) : word;
  endtask

  task automatic release_strobes();
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    core_valid_i = 1'b0;
  endtask

  task automatic run_step(input int idx);
    step_t s;
    int    errors_before;
    s             = steps[idx];
    errors_before = errors;
    synch_cnt     = 0;
    resynch_cnt   = 0;
    busy_cnt      = 0;
    setback_seen  = SetbackNone;
    drive_step(s);
    for (int c = 0; c < s.wait_cyc; c++) begin
      @(negedge clk_i);
      sample_outputs();
      if (c == 0) release_strobes();
    end
    check_count("sw_synch_req_o pulses", synch_cnt, s.exp_synch);
    check_count("sw_resynch_req_o pulses", resynch_cnt, s.exp_resynch);
    check_count("recovery_busy_o cycles", busy_cnt, s.exp_busy);
    check_setback("setback_o", setback_seen, s.exp_setback);
    check_bit("grp_in_independent_o", grp_in_independent_o, s.exp_indep);
    check_bit("rapid_recovery_en_o", rapid_recovery_en_o, s.exp_rapid);
    if (s.rd && s.addr == DMR_STATUS_ADDR) begin
      check_mode("reg_rdata_o", dmr_mode_e'(reg_rdata_o[1:0]), dmr_mode_e'(s.exp_rdata[1:0]));
    end else if (s.rd) begin
      check_word("reg_rdata_o", reg_rdata_o, s.exp_rdata);
    end
    if (errors == errors_before) begin
      $display("Test %0d passed: %s", idx, names[idx]);
    end else begin
      $display("Test %0d failed: %s", idx, names[idx]);
      failed_steps++;
    end
  endtask

  // Column order is fetch synch rd wr addr wdata cmp differ, then
  // wait synch_pulses resynch_pulses setback busy_cycles indep rapid rdata
  task automatic fill_table();
    names[0]  = "reset state";
    steps[0]  = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_STATUS_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b1, 1'b0, RegWidth'(NON_DMR)};
    names[1]  = "enable requests synch";
    steps[1]  = '{1'b1, 1'b0, 1'b0, 1'b1, DMR_ENABLE_ADDR, 32'h1, 1'b0, 1'b0,
                  4, 1, 0, SetbackNone, 0, 1'b1, 1'b0, 32'h0};
    names[2]  = "synch joins the pair";
    steps[2]  = '{1'b1, 1'b1, 1'b0, 1'b0, DMR_ENABLE_ADDR, 32'h0, 1'b0, 1'b0,
                  4, 0, 0, SetbackJoin, 0, 1'b0, 1'b0, 32'h0};
    names[3]  = "mode after join";
    steps[3]  = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_STATUS_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b0, 1'b0, RegWidth'(DMR_RUN)};
    names[4]  = "equal words";
    steps[4]  = '{1'b1, 1'b0, 1'b0, 1'b0, DMR_ENABLE_ADDR, 32'h0, 1'b1, 1'b0,
                  3, 0, 0, SetbackNone, 0, 1'b0, 1'b0, 32'h0};
    names[5]  = "mismatch requests resynch";
    steps[5]  = '{1'b1, 1'b0, 1'b0, 1'b0, DMR_ENABLE_ADDR, 32'h0, 1'b1, 1'b1,
                  3, 0, 1, SetbackNone, 0, 1'b0, 1'b0, 32'h0};
    names[6]  = "mismatch count one";
    steps[6]  = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_MISMATCH_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b0, 1'b0, 32'h1};
    names[7]  = "rapid recovery on";
    steps[7]  = '{1'b1, 1'b0, 1'b0, 1'b1, DMR_CONFIG_ADDR, 32'h1, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b0, 1'b1, 32'h0};
    names[8]  = "mismatch starts restore";
    steps[8]  = '{1'b1, 1'b0, 1'b0, 1'b0, DMR_ENABLE_ADDR, 32'h0, 1'b1, 1'b1,
                  RestoreCycles + 6, 0, 0, SetbackNone, RestoreCycles + 1, 1'b0, 1'b1,
                  32'h0};
    names[9]  = "mode back to run";
    steps[9]  = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_STATUS_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b0, 1'b1, RegWidth'(DMR_RUN)};
    names[10] = "force starts restore";
    steps[10] = '{1'b1, 1'b0, 1'b0, 1'b1, DMR_CONFIG_ADDR, 32'h3, 1'b0, 1'b0,
                  RestoreCycles + 6, 0, 0, SetbackNone, RestoreCycles + 1, 1'b0, 1'b1,
                  32'h0};
    names[11] = "force bit reads zero";
    steps[11] = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_CONFIG_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b0, 1'b1, 32'h1};
    names[12] = "mismatch count two";
    steps[12] = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_MISMATCH_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b0, 1'b1, 32'h2};
    names[13] = "disable splits the pair";
    steps[13] = '{1'b1, 1'b0, 1'b0, 1'b1, DMR_ENABLE_ADDR, 32'h0, 1'b0, 1'b0,
                  3, 0, 0, SetbackSplit, 0, 1'b1, 1'b1, 32'h0};
    names[14] = "mode after split";
    steps[14] = '{1'b1, 1'b0, 1'b1, 1'b0, DMR_STATUS_ADDR, 32'h0, 1'b0, 1'b0,
                  2, 0, 0, SetbackNone, 0, 1'b1, 1'b1, RegWidth'(NON_DMR)};
  endtask

  initial begin
    rst_ni        = 1'b0;
    reg_valid_i   = 1'b0;
    reg_write_i   = 1'b0;
    reg_addr_i    = DMR_ENABLE_ADDR;
    reg_wdata_i   = '0;
    fetch_en_i    = 1'b0;
    cores_synch_i = 1'b0;
    core_valid_i  = 1'b0;
    core_a_data_i = '0;
    core_b_data_i = '0;
    fill_table();
    cycle_limit = ResetCycles + 100;
    foreach (steps[i]) cycle_limit += steps[i].wait_cyc;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (steps[i]) run_step(i);
    $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
             NumSteps, failed_steps, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/dmr_reg_pkg.sv
logic/dmr_mode_pkg.sv
logic/dmr_ctrl_regs.sv
logic/dmr_lockstep_cmp.sv
logic/dmr_recovery_seq.sv
logic/dmr_ctrl.sv
logic/dmr_subsys_top.sv
tb/tb_dmr_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the DMR subsystem testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_dmr_subsys -Mdir obj_dir -o Vtb_dmr_subsys \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vtb_dmr_subsys > sim.log 2>&1 || true
cat sim.log
grep -qx "No errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
